//--- fetch_pkg.sv
package fetch_pkg;

	// Byte address width seen by the fetch unit
	localparam int alen = 32;

	// Widest instruction handed out with compressed ones zero-extended to it
	localparam int ilen = 32;

	// One cache line is exactly one bus beat
	localparam int line_bits = 64;

	// Byte offset bits inside a line (8 bytes)
	localparam int align_bits = 3;

	// Address of a whole line, without the byte offset
	localparam int line_addr_bits = alen - align_bits;

	// Direct-mapped geometry
	localparam int cache_lines = 16;
	localparam int index_bits = 4; // Must match cache_lines

	// What is left of a line address once the index is taken off
	localparam int tag_bits = line_addr_bits - index_bits;

	// AXI read response for a normal access
	localparam logic [1:0] resp_okay = 2'b00;

endpackage

//--- axi_read_if.sv
`timescale 1ns/10ps

// Read half of an AXI4-Lite bus that moves one line per beat
interface axi_read_if import fetch_pkg::*; ();

	// Read address channel
	logic [alen-1:0] araddr;
	logic [2:0] arprot;
	logic arvalid;
	logic arready;

	// Read data channel
	logic [line_bits-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	modport master (
		output araddr, arprot, arvalid, rready,
		input arready, rdata, rresp, rvalid
	);

	modport slave (
		input araddr, arprot, arvalid, rready,
		output arready, rdata, rresp, rvalid
	);

endinterface

//--- icache_if.sv
`timescale 1ns/10ps

interface icache_if import fetch_pkg::*; ();

	// Fill port written from the returning bus beat
	logic write_enable;
	logic [line_addr_bits-1:0] waddr;
	logic [line_bits-1:0] wdata;

	// Lookup port with its result one cycle after raddr
	logic [line_addr_bits-1:0] raddr;
	logic [line_bits-1:0] rdata;
	logic lookup_valid;

	modport fetch (
		output write_enable, waddr, wdata, raddr,
		input rdata, lookup_valid
	);

	modport cache (
		input write_enable, waddr, wdata, raddr,
		output rdata, lookup_valid
	);

endinterface

//--- icache.sv
`timescale 1ns/10ps

// Direct-mapped instruction cache holding one line per index
module icache import fetch_pkg::*; (
	input logic clk,
	input logic rst,
	icache_if.cache port
);

	logic [line_bits-1:0] lines [cache_lines];
	logic [tag_bits-1:0] tags [cache_lines];
	logic [cache_lines-1:0] valid;

	logic [index_bits-1:0] w_index;
	logic [tag_bits-1:0] w_tag;
	logic [index_bits-1:0] r_index;
	logic [tag_bits-1:0] r_tag;
	logic bypass;

	assign w_index = port.waddr[index_bits-1:0];
	assign w_tag = port.waddr[line_addr_bits-1:index_bits];
	assign r_index = port.raddr[index_bits-1:0];
	assign r_tag = port.raddr[line_addr_bits-1:index_bits];

	// A line being filled in this cycle is handed straight to the lookup
	assign bypass = port.write_enable && (port.waddr == port.raddr);

	// Line and tag storage
	always_ff @(posedge clk) begin
		if (port.write_enable) begin
			lines[w_index] <= port.wdata;
			tags[w_index] <= w_tag;
		end
	end

	// All entries become invalid in the single reset cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else if (port.write_enable) begin
			valid[w_index] <= 1'b1;
		end
	end

	// Registered lookup data
	always_ff @(posedge clk) begin
		if (bypass) begin
			port.rdata <= port.wdata;
		end else begin
			port.rdata <= lines[r_index];
		end
	end

	// Hit flag lines up with the registered data
	always_ff @(posedge clk) begin
		if (rst) begin
			port.lookup_valid <= 1'b0;
		end else begin
			port.lookup_valid <= bypass || (valid[r_index] && (tags[r_index] == r_tag));
		end
	end

endmodule

//--- ifetch.sv
`timescale 1ns/10ps

module ifetch import fetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [alen-1:0] pc,
	output logic stall_next,
	output logic ifetch_exception,
	output logic [ilen-1:0] instruction,
	axi_read_if.master bus,
	icache_if.fetch cache
);

	typedef enum logic [2:0] {
		st_start_lookup,
		st_check_first,
		st_start_first_read,
		st_wait_first_read,
		st_check_second,
		st_start_second_read,
		st_wait_second_read,
		st_exception
	} state_t;

	state_t state;
	state_t state_d;
	logic [alen-1:0] fetch_pc; // Address of the instruction being fetched
	logic [line_addr_bits-1:0] next_line; // Line after the one holding fetch_pc
	logic [15:0] low_half; // First line's top half-word of a crossing instruction

	logic [align_bits-2:0] half_sel;
	logic [line_bits-1:0] src_line;
	logic [ilen-1:0] word;
	logic is_short;
	logic too_long;
	logic crosses;
	logic [alen-1:0] next_pc;
	logic [line_addr_bits-1:0] lookup_line;
	logic [ilen-1:0] assembled;
	logic advance;
	logic hold_low;
	logic emit;
	logic raise;

	// Up to 32 bits from a half-word on with zeros past the end of the line
	function automatic logic [ilen-1:0] word_at(input logic [line_bits-1:0] line,
		input logic [align_bits-2:0] half);
		logic [line_bits+15:0] padded;
		padded = {16'h0000, line};
		return padded[{half, 4'b0000} +: ilen];
	endfunction

	// Decode works on the bus beat while waiting for it and on the cache otherwise
	assign half_sel = fetch_pc[align_bits-1:1];
	assign src_line = (state == st_wait_first_read) ? bus.rdata : cache.rdata;
	assign word = word_at(src_line, half_sel);
	assign is_short = word[1:0] != 2'b11;
	assign too_long = word[4:0] == 5'b11111;
	assign crosses = !is_short && (&half_sel); // Full length in the last half-word
	assign next_pc = fetch_pc + (is_short ? alen'(2) : alen'(4));

	// fetch_pc already points into the second line when the second read starts
	assign bus.araddr = {fetch_pc[alen-1:align_bits], {align_bits{1'b0}}};
	assign bus.arprot = 3'b000;
	assign bus.arvalid = (state == st_start_first_read) || (state == st_start_second_read);
	assign bus.rready = (state == st_wait_first_read) || (state == st_wait_second_read);

	// Every returned beat is stored, so later fetches from that line hit
	assign cache.write_enable = bus.rready && bus.rvalid;
	assign cache.waddr = fetch_pc[alen-1:align_bits];
	assign cache.wdata = bus.rdata;
	assign cache.raddr = lookup_line;

	always_comb begin
		state_d = state;
		lookup_line = fetch_pc[alen-1:align_bits];
		assembled = is_short ? {16'h0000, word[15:0]} : word;
		advance = 1'b0;
		hold_low = 1'b0;
		emit = 1'b0;
		raise = 1'b0;
		case (state)
			st_start_lookup: begin
				lookup_line = pc[alen-1:align_bits];
				if (pc[0]) begin
					raise = 1'b1; // Instructions sit on half-word boundaries
				end else begin
					state_d = st_check_first;
				end
			end
			st_check_first: begin
				lookup_line = next_pc[alen-1:align_bits]; // Prime the following fetch
				if (!cache.lookup_valid) begin
					state_d = st_start_first_read;
				end else if (too_long) begin
					raise = 1'b1;
				end else if (crosses) begin
					advance = 1'b1;
					hold_low = 1'b1;
					state_d = st_check_second;
				end else begin
					advance = 1'b1;
					emit = 1'b1;
				end
			end
			st_start_first_read: begin
				lookup_line = next_line;
				if (bus.arready) begin
					state_d = st_wait_first_read;
				end
			end
			st_wait_first_read: begin
				lookup_line = next_line; // Second line is probed while the beat is awaited
				if (bus.rvalid) begin
					lookup_line = next_pc[alen-1:align_bits];
					if (too_long) begin
						raise = 1'b1;
					end else begin
						advance = 1'b1;
						if (!crosses) begin
							emit = 1'b1;
							state_d = st_check_first;
						end else if (cache.lookup_valid) begin
							emit = 1'b1;
							assembled = {cache.rdata[15:0], word[15:0]};
							state_d = st_check_first;
						end else begin
							hold_low = 1'b1;
							state_d = st_start_second_read;
						end
					end
				end
			end
			st_check_second: begin
				if (cache.lookup_valid) begin
					emit = 1'b1;
					assembled = {cache.rdata[15:0], low_half};
					state_d = st_check_first;
				end else begin
					state_d = st_start_second_read;
				end
			end
			st_start_second_read: begin
				if (bus.arready) begin
					state_d = st_wait_second_read;
				end
			end
			st_wait_second_read: begin
				if (bus.rvalid) begin
					emit = 1'b1;
					assembled = {bus.rdata[15:0], low_half};
					state_d = st_check_first;
				end
			end
			default: begin
				// Exception holds until reset
			end
		endcase
		if (raise) begin
			state_d = st_exception;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_start_lookup;
			stall_next <= 1'b1;
			ifetch_exception <= 1'b0;
		end else begin
			state <= state_d;
			stall_next <= !(emit || raise || ifetch_exception); // Low for one cycle per instruction
			ifetch_exception <= ifetch_exception || raise;
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_start_lookup) begin
			fetch_pc <= pc;
			next_line <= pc[alen-1:align_bits] + 1'b1;
		end else if (advance) begin
			fetch_pc <= next_pc;
			next_line <= next_pc[alen-1:align_bits] + 1'b1;
		end
		if (hold_low) begin
			low_half <= word[15:0];
		end
		if (emit) begin
			instruction <= assembled;
		end
	end

endmodule

//--- fetch_top.sv
`timescale 1ns/10ps

module fetch_top import fetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [alen-1:0] pc,
	output logic stall_next,
	output logic ifetch_exception,
	output logic [ilen-1:0] instruction,
	output logic [alen-1:0] araddr,
	output logic [2:0] arprot,
	output logic arvalid,
	input logic arready,
	input logic [line_bits-1:0] rdata,
	input logic [1:0] rresp,
	input logic rvalid,
	output logic rready
);

	axi_read_if bus_if ();
	icache_if cache_if ();

	// Slave side of the read bus goes out to the pins
	assign araddr = bus_if.araddr;
	assign arprot = bus_if.arprot;
	assign arvalid = bus_if.arvalid;
	assign rready = bus_if.rready;
	assign bus_if.arready = arready;
	assign bus_if.rdata = rdata;
	assign bus_if.rresp = rresp;
	assign bus_if.rvalid = rvalid;

	ifetch i_ifetch (
		.clk(clk),
		.rst(rst),
		.pc(pc),
		.stall_next(stall_next),
		.ifetch_exception(ifetch_exception),
		.instruction(instruction),
		.bus(bus_if),
		.cache(cache_if)
	);

	icache i_icache (
		.clk(clk),
		.rst(rst),
		.port(cache_if)
	);

endmodule

//--- fetch_top_sva.sv
`timescale 1ns/10ps

module fetch_top_sva import fetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic stall_next,
	input logic ifetch_exception,
	input logic [alen-1:0] araddr,
	input logic arvalid,
	input logic arready,
	input logic [1:0] rresp,
	input logic rvalid
);

	// Every beat from memory must carry a normal response
	assert property (@(posedge clk) disable iff (rst) rvalid |-> rresp == resp_okay)
		else $error("Read data returned with a response other than OKAY");

	assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("Read address dropped or changed before arready");

	// Once raised the exception keeps stall_next low until reset
	assert property (@(posedge clk) disable iff (rst)
		ifetch_exception |-> !stall_next ##1 ifetch_exception)
		else $error("Fetch exception not held with stall_next low");

endmodule

bind fetch_top fetch_top_sva i_fetch_top_sva (
	.clk(clk),
	.rst(rst),
	.stall_next(stall_next),
	.ifetch_exception(ifetch_exception),
	.araddr(araddr),
	.arvalid(arvalid),
	.arready(arready),
	.rresp(rresp),
	.rvalid(rvalid)
);

//--- tb_fetch_top.sv
`timescale 1ns/10ps

module tb_fetch_top import fetch_pkg::*; ();

	typedef struct {
		string name;
		logic [alen-1:0] pc;
		int count; // Instructions delivered before the run ends or the exception
		bit exception;
		int reads; // Distinct lines the walked instructions touch
	} run_t;

	logic clk;
	logic rst;
	logic [alen-1:0] pc;
	logic stall_next;
	logic ifetch_exception;
	logic arvalid;
	logic rready;
	logic [ilen-1:0] instruction;
	logic [alen-1:0] araddr;
	logic [2:0] arprot;
	logic arready = 1'b0;
	logic [line_bits-1:0] rdata = '0;
	logic [1:0] rresp = resp_okay;
	logic rvalid = 1'b0;

	logic [7:0] mem [256];
	integer seed = 32'h70a0_3162;
	logic pending = 1'b0;
	logic [7:0] line_addr = '0;
	int wait_cnt = 0;
	int reads = 0; // Address handshakes since the last reset
	run_t runs [6];

	// Byte address in the top eight bits and the half-word below it
	logic [23:0] placed [11] = '{24'h04_0513, 24'h06_0010, 24'h0e_8593, 24'h10_0002,
		24'h16_0537, 24'h18_1234, 24'h1e_4603, 24'h20_beef, 24'h44_2083, 24'h46_0041,
		24'h4c_007f};

	fetch_top i_fetch_top (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [15:0] half_at(input logic [alen-1:0] addr);
		return {mem[addr[7:0] + 8'd1], mem[addr[7:0]]};
	endfunction

	function automatic logic [line_bits-1:0] line_of(input logic [7:0] base);
		logic [line_bits-1:0] line;
		for (int k = 0; k < 8; k++) begin
			line[8*k +: 8] = mem[base + 8'(k)]; // Little-endian beat
		end
		return line;
	endfunction

	// Background is compressed only and full-length ones are placed on top
	task automatic fill_memory();
		logic [7:0] a;
		for (int i = 0; i < 128; i++) begin
			a = 8'(2 * i);
			{mem[a + 8'd1], mem[a]} = {a ^ 8'hc3, a[7:2], 1'b0, a[1]};
		end
		foreach (placed[j]) begin
			{mem[placed[j][23:16] + 8'd1], mem[placed[j][23:16]]} = placed[j][15:0];
		end
	endtask

	task automatic stop_run();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			stop_run();
		end
	endtask

	task automatic wait_for_stall_low(input string name);
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (stall_next) begin
			cycles++;
			if (cycles > 200) begin
				$display("Run %s timed out waiting 200 cycles for stall_next to go low", name);
				stop_run();
			end else begin
				@(posedge clk);
			end
		end
	endtask

	task automatic apply_reset(input logic [alen-1:0] start_pc);
		@(posedge clk);
		rst <= 1'b1;
		pc <= start_pc;
		repeat (8) @(posedge clk);
		check("reset stall_next", 1, stall_next);
		check("reset arvalid", 0, arvalid);
		check("reset rready", 0, rready);
		rst <= 1'b0;
	endtask

	// Bus slave with a random wait of up to three cycles before arready and rvalid
	always @(posedge clk) begin
		if (rst) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			pending <= 1'b0;
			reads <= 0;
		end else if (arvalid && arready) begin
			check("read address arprot", 0, arprot);
			arready <= 1'b0;
			pending <= 1'b1;
			line_addr <= araddr[7:0];
			reads <= reads + 1;
			wait_cnt <= $unsigned($random(seed)) % 4;
		end else if (rvalid && rready) begin
			rvalid <= 1'b0;
			pending <= 1'b0;
			wait_cnt <= $unsigned($random(seed)) % 4;
		end else if (wait_cnt > 0) begin
			wait_cnt <= wait_cnt - 1;
		end else if (pending) begin
			rvalid <= 1'b1;
			rdata <= line_of(line_addr);
		end else if (arvalid) begin
			arready <= 1'b1;
		end
	end

	initial begin
		run_t r;
		logic [alen-1:0] walk;
		logic [15:0] low;
		logic [ilen-1:0] expected;
		rst = 1'b1;
		pc = '0;
		runs[0] = '{"mixed", 32'h00, 14, 1'b0, 5};
		runs[1] = '{"crossing", 32'h16, 4, 1'b0, 3};
		runs[2] = '{"odd_pc", 32'h21, 0, 1'b1, 0};
		runs[3] = '{"too_long", 32'h40, 5, 1'b1, 2};
		runs[4] = '{"long_stream", 32'h80, 40, 1'b0, 10};
		runs[5] = '{"mixed_again", 32'h00, 14, 1'b0, 5}; // Same walk under other delays
		fill_memory();
		foreach (runs[n]) begin
			r = runs[n];
			apply_reset(r.pc);
			walk = r.pc;
			for (int i = 0; i < r.count; i++) begin
				low = half_at(walk);
				if (low[1:0] != 2'b11) begin
					expected = {16'h0000, low};
					walk = walk + 2;
				end else begin
					expected = {half_at(walk + 2), low};
					walk = walk + 4;
				end
				wait_for_stall_low(r.name);
				check($sformatf("%s instruction %0d", r.name, i), expected, instruction);
				check($sformatf("%s exception at %0d", r.name, i), 0, ifetch_exception);
			end
			if (r.exception) begin
				wait_for_stall_low(r.name);
				check($sformatf("%s exception", r.name), 1, ifetch_exception);
				repeat (6) begin
					@(posedge clk);
					check($sformatf("%s exception held", r.name), 1, ifetch_exception);
					check($sformatf("%s stall_next held", r.name), 0, stall_next);
				end
			end
			check($sformatf("%s line reads", r.name), r.reads, reads);
		end
		$display("No errors");
		$finish;
	end

endmodule

//--- compile.f
fetch_pkg.sv
axi_read_if.sv
icache_if.sv
icache.sv
ifetch.sv
fetch_top.sv
fetch_top_sva.sv
tb_fetch_top.sv
